// ==== source/ProcessorPackage.sv ====
package ProcessorPackage;

	// Datapath widths
	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;

	// Primary opcode field values
	typedef enum logic [5:0] {
		OpRType = 6'd0,
		OpAddi = 6'd8,
		OpAndi = 6'd12,
		OpOri = 6'd13,
		OpSw = 6'd43,
		OpHalt = 6'd63
	} OpCode;

	// Function field values for R-type, also reused as the ALU operation
	typedef enum logic [5:0] {
		FunctSll = 6'd0,
		FunctAdd = 6'd32,
		FunctSub = 6'd34,
		FunctAnd = 6'd36,
		FunctOr = 6'd37,
		FunctSlt = 6'd42
	} AluFunct;

	// Run sequencing
	typedef enum logic [1:0] {
		StateIdle,
		StateFill,
		StateRun,
		StateHalted
	} RunState;

	// Instruction field positions
	localparam int OpcodeMsb = 31;
	localparam int OpcodeLsb = 26;
	localparam int RsMsb = 25;
	localparam int RsLsb = 21;
	localparam int RtMsb = 20;
	localparam int RtLsb = 16;
	localparam int RdMsb = 15;
	localparam int RdLsb = 11;
	localparam int ShamtMsb = 10;
	localparam int ShamtLsb = 6;
	localparam int FunctMsb = 5;
	localparam int FunctLsb = 0;
	localparam int ImmediateMsb = 15;
	localparam int ImmediateLsb = 0;

endpackage

// ==== source/HostPortIf.sv ====
interface HostPortIf;

	// Level-based request, valid while hostEnable is high
	logic hostEnable;
	// Low picks instruction memory, high picks data memory
	logic hostSelect;
	logic hostWrite;
	logic [ProcessorPackage::DataWidth-1:0] hostAddress;
	logic [ProcessorPackage::DataWidth-1:0] hostWriteData;
	// Registered data memory read, holds between reads
	logic [ProcessorPackage::DataWidth-1:0] hostReadData;

	modport memory (
		input hostEnable,
		input hostSelect,
		input hostWrite,
		input hostAddress,
		input hostWriteData,
		output hostReadData
	);

endinterface

// ==== source/RegisterFile.sv ====
module RegisterFile (
	input logic clk,
	input logic rst,
	input logic [ProcessorPackage::RegAddrWidth-1:0] readAddress0,
	input logic [ProcessorPackage::RegAddrWidth-1:0] readAddress1,
	input logic writeEnable,
	input logic [ProcessorPackage::RegAddrWidth-1:0] writeAddress,
	input logic [ProcessorPackage::DataWidth-1:0] writeData,
	output logic [ProcessorPackage::DataWidth-1:0] readValue0,
	output logic [ProcessorPackage::DataWidth-1:0] readValue1
);
	import ProcessorPackage::*;

	logic [DataWidth-1:0] registers [2**RegAddrWidth];

	// Register zero never takes a write
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 2**RegAddrWidth; i++) begin
				registers[i] <= '0;
			end
		end else if (writeEnable && (writeAddress != '0)) begin
			registers[writeAddress] <= writeData;
		end
	end

	// Combinational reads, zero forced for r0
	assign readValue0 = (readAddress0 == '0) ? '0 : registers[readAddress0];
	assign readValue1 = (readAddress1 == '0) ? '0 : registers[readAddress1];

endmodule

// ==== source/RunController.sv ====
module RunController (
	input logic clk,
	input logic rst,
	input logic start,
	input logic pause,
	input logic hostEnable,
	input logic haltSeen,
	output logic pcClear,
	output logic pcAdvance,
	output logic fetchEnable,
	output logic executeValid,
	output logic halted
);
	import ProcessorPackage::*;

	RunState state;
	RunState nextState;
	logic startAccepted;
	logic stepRun;

	always_comb begin
		// Start only counts from a stopped state with the host port quiet
		startAccepted = start && !hostEnable && (state == StateIdle || state == StateHalted);
		// One instruction retires per unpaused run cycle
		stepRun = (state == StateRun) && !pause;
		pcClear = startAccepted;
		// No fetch past the halt word, so the counter stops on it
		fetchEnable = (state == StateFill) || (stepRun && !haltSeen);
		pcAdvance = fetchEnable;
		executeValid = stepRun;
		nextState = state;
		case (state)
			StateIdle, StateHalted: begin
				if (startAccepted) begin
					nextState = StateFill;
				end
			end
			// Word 0 is loaded here, first execute follows
			StateFill: begin
				nextState = StateRun;
			end
			StateRun: begin
				if (stepRun && haltSeen) begin
					nextState = StateHalted;
				end
			end
			default: begin
				nextState = StateIdle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= StateIdle;
			halted <= 1'b0;
		end else begin
			state <= nextState;
			// Flag trails the state by a cycle and drops on restart
			halted <= (state == StateHalted) && !startAccepted;
		end
	end

	// Host port only in use while idle or after halted has risen
	assert property (@(posedge clk) disable iff (!rst)
		hostEnable |-> (state == StateIdle || halted));

endmodule

// ==== source/ProgramCounter.sv ====
module ProgramCounter #(
	parameter int ProgramAddressWidth = 6
) (
	input logic clk,
	input logic rst,
	input logic pcClear,
	input logic pcAdvance,
	output logic [ProgramAddressWidth-1:0] pc
);

	// Clear wins over advance
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
		end else if (pcClear) begin
			pc <= '0;
		end else if (pcAdvance) begin
			pc <= pc + 1'b1;
		end
	end

	// Running off the end of program storage means the halt is missing
	assert property (@(posedge clk) disable iff (!rst) pcAdvance |-> (pc != '1));

endmodule

// ==== source/InstructionMemory.sv ====
module InstructionMemory #(
	parameter int ProgramAddressWidth = 6
) (
	input logic clk,
	input logic rst,
	input logic [ProgramAddressWidth-1:0] pc,
	input logic fetchEnable,
	HostPortIf.memory host,
	output logic [ProcessorPackage::DataWidth-1:0] instruction
);
	import ProcessorPackage::*;

	logic [DataWidth-1:0] programWords [2**ProgramAddressWidth];
	logic hostWriteHit;

	// Host writes go here when select is low
	assign hostWriteHit = host.hostEnable && host.hostWrite && !host.hostSelect;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 2**ProgramAddressWidth; i++) begin
				programWords[i] <= '0;
			end
		end else if (hostWriteHit) begin
			programWords[host.hostAddress[ProgramAddressWidth-1:0]] <= host.hostWriteData;
		end
	end

	// Registered fetch, word holds while fetch is off
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			instruction <= '0;
		end else if (fetchEnable) begin
			instruction <= programWords[pc];
		end
	end

endmodule

// ==== source/ExecuteUnit.sv ====
module ExecuteUnit #(
	parameter int DataAddressWidth = 6
) (
	input logic clk,
	input logic rst,
	input logic [ProcessorPackage::DataWidth-1:0] instruction,
	input logic executeValid,
	output logic haltSeen,
	output logic storeEnable,
	output logic [DataAddressWidth-1:0] storeAddress,
	output logic [ProcessorPackage::DataWidth-1:0] storeData
);
	import ProcessorPackage::*;

	localparam int ImmediateWidth = ImmediateMsb - ImmediateLsb + 1;

	OpCode opCode;
	AluFunct functCode;
	AluFunct aluOp;
	logic [RegAddrWidth-1:0] rsAddress;
	logic [RegAddrWidth-1:0] rtAddress;
	logic [RegAddrWidth-1:0] rdAddress;
	logic [RegAddrWidth-1:0] shamt;
	logic [ImmediateWidth-1:0] immediate;
	logic [DataWidth-1:0] signImmediate;
	logic [DataWidth-1:0] zeroImmediate;
	logic [DataWidth-1:0] rsValue;
	logic [DataWidth-1:0] rtValue;
	logic [DataWidth-1:0] operandB;
	logic [DataWidth-1:0] aluResult;
	logic regWrite;
	logic [RegAddrWidth-1:0] writeAddress;

	// Field split
	assign opCode = OpCode'(instruction[OpcodeMsb:OpcodeLsb]);
	assign functCode = AluFunct'(instruction[FunctMsb:FunctLsb]);
	assign rsAddress = instruction[RsMsb:RsLsb];
	assign rtAddress = instruction[RtMsb:RtLsb];
	assign rdAddress = instruction[RdMsb:RdLsb];
	assign shamt = instruction[ShamtMsb:ShamtLsb];
	assign immediate = instruction[ImmediateMsb:ImmediateLsb];
	assign signImmediate = {{(DataWidth-ImmediateWidth){immediate[ImmediateWidth-1]}}, immediate};
	assign zeroImmediate = {{(DataWidth-ImmediateWidth){1'b0}}, immediate};

	// Decode into ALU op, operand source and destination
	always_comb begin
		aluOp = functCode;
		operandB = rtValue;
		regWrite = 1'b0;
		writeAddress = rdAddress;
		case (opCode)
			OpRType: begin
				// Unknown function codes leave the registers alone
				case (functCode)
					FunctSll, FunctAdd, FunctSub, FunctAnd, FunctOr, FunctSlt: regWrite = 1'b1;
					default: regWrite = 1'b0;
				endcase
			end
			OpAddi: begin
				aluOp = FunctAdd;
				operandB = signImmediate;
				regWrite = 1'b1;
				writeAddress = rtAddress;
			end
			OpAndi: begin
				aluOp = FunctAnd;
				operandB = zeroImmediate;
				regWrite = 1'b1;
				writeAddress = rtAddress;
			end
			OpOri: begin
				aluOp = FunctOr;
				operandB = zeroImmediate;
				regWrite = 1'b1;
				writeAddress = rtAddress;
			end
			default: begin
				regWrite = 1'b0;
			end
		endcase
	end

	// ALU
	always_comb begin
		case (aluOp)
			FunctSll: aluResult = operandB << shamt;
			FunctAdd: aluResult = rsValue + operandB;
			FunctSub: aluResult = rsValue - operandB;
			FunctAnd: aluResult = rsValue & operandB;
			FunctOr: aluResult = rsValue | operandB;
			// Signed compare
			FunctSlt: aluResult = {{(DataWidth-1){1'b0}}, $signed(rsValue) < $signed(operandB)};
			default: aluResult = '0;
		endcase
	end

	// Word address from base plus offset, data from rt
	assign storeEnable = executeValid && (opCode == OpSw);
	assign storeAddress = rsValue[DataAddressWidth-1:0] + signImmediate[DataAddressWidth-1:0];
	assign storeData = rtValue;
	assign haltSeen = (opCode == OpHalt);

	RegisterFile registerFile (
		.clk(clk),
		.rst(rst),
		.readAddress0(rsAddress),
		.readAddress1(rtAddress),
		.writeEnable(executeValid && regWrite),
		.writeAddress(writeAddress),
		.writeData(aluResult),
		.readValue0(rsValue),
		.readValue1(rtValue)
	);

endmodule

// ==== source/DataMemory.sv ====
module DataMemory #(
	parameter int DataAddressWidth = 6
) (
	input logic clk,
	input logic rst,
	input logic storeEnable,
	input logic [DataAddressWidth-1:0] storeAddress,
	input logic [ProcessorPackage::DataWidth-1:0] storeData,
	HostPortIf.memory host
);
	import ProcessorPackage::*;

	logic [DataWidth-1:0] resultWords [2**DataAddressWidth];
	logic [DataAddressWidth-1:0] hostIndex;
	logic hostWriteHit;
	logic hostReadHit;

	assign hostIndex = host.hostAddress[DataAddressWidth-1:0];
	assign hostWriteHit = host.hostEnable && host.hostSelect && host.hostWrite;
	assign hostReadHit = host.hostEnable && host.hostSelect && !host.hostWrite;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 2**DataAddressWidth; i++) begin
				resultWords[i] <= '0;
			end
		end else if (storeEnable) begin
			resultWords[storeAddress] <= storeData;
		end else if (hostWriteHit) begin
			resultWords[hostIndex] <= host.hostWriteData;
		end
	end

	// Read data one clock after the address, held otherwise
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			host.hostReadData <= '0;
		end else if (hostReadHit) begin
			host.hostReadData <= resultWords[hostIndex];
		end
	end

	// Host must stay off the port while the program runs
	assert property (@(posedge clk) disable iff (!rst) storeEnable |-> !host.hostEnable);

endmodule

// ==== source/Processor.sv ====
module Processor #(
	parameter int ProgramAddressWidth = 6,
	parameter int DataAddressWidth = 6
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic pause,
	input logic hostEnable,
	input logic hostSelect,
	input logic hostWrite,
	input logic [ProcessorPackage::DataWidth-1:0] hostAddress,
	input logic [ProcessorPackage::DataWidth-1:0] hostWriteData,
	output logic [ProcessorPackage::DataWidth-1:0] hostReadData,
	output logic halted
);
	import ProcessorPackage::*;

	// Sequencing lines
	logic pcClear;
	logic pcAdvance;
	logic fetchEnable;
	logic executeValid;
	logic haltSeen;

	// Fetch path
	logic [ProgramAddressWidth-1:0] pc;
	logic [DataWidth-1:0] instruction;

	// Store request into data memory
	logic storeEnable;
	logic [DataAddressWidth-1:0] storeAddress;
	logic [DataWidth-1:0] storeData;

	// Host access shared by both memories
	HostPortIf hostPort ();

	assign hostPort.hostEnable = hostEnable;
	assign hostPort.hostSelect = hostSelect;
	assign hostPort.hostWrite = hostWrite;
	assign hostPort.hostAddress = hostAddress;
	assign hostPort.hostWriteData = hostWriteData;
	assign hostReadData = hostPort.hostReadData;

	RunController runController (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pause(pause),
		.hostEnable(hostEnable),
		.haltSeen(haltSeen),
		.pcClear(pcClear),
		.pcAdvance(pcAdvance),
		.fetchEnable(fetchEnable),
		.executeValid(executeValid),
		.halted(halted)
	);

	ProgramCounter #(.ProgramAddressWidth(ProgramAddressWidth)) programCounter (
		.clk(clk),
		.rst(rst),
		.pcClear(pcClear),
		.pcAdvance(pcAdvance),
		.pc(pc)
	);

	InstructionMemory #(.ProgramAddressWidth(ProgramAddressWidth)) instructionMemory (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.fetchEnable(fetchEnable),
		.host(hostPort.memory),
		.instruction(instruction)
	);

	ExecuteUnit #(.DataAddressWidth(DataAddressWidth)) executeUnit (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.executeValid(executeValid),
		.haltSeen(haltSeen),
		.storeEnable(storeEnable),
		.storeAddress(storeAddress),
		.storeData(storeData)
	);

	DataMemory #(.DataAddressWidth(DataAddressWidth)) dataMemory (
		.clk(clk),
		.rst(rst),
		.storeEnable(storeEnable),
		.storeAddress(storeAddress),
		.storeData(storeData),
		.host(hostPort.memory)
	);

endmodule

// ==== tb/ProcessorTb.sv ====
module ProcessorTb;

	// Mirrors of the DUT parameters
	localparam int ProgramAddressWidth = 6;
	localparam int DataAddressWidth = 6;
	localparam int DataWords = 2**DataAddressWidth;
	localparam int RowCount = 13;
	localparam int ProgramLength = 6;
	localparam int PauseCycles = 6;
	// Load, start, pause and readback overhead per row
	localparam int LoadCycles = ProgramLength + PauseCycles + 2 * RowCount + 8;
	localparam int ResetCycles = 8 + 2 * DataWords + 4;
	localparam int CycleLimit = 2 * (RowCount * (ProgramLength + LoadCycles) + ResetCycles);

	// Opcode and function encodings
	localparam logic [5:0] AddiOp = 6'd8;
	localparam logic [5:0] AndiOp = 6'd12;
	localparam logic [5:0] OriOp = 6'd13;
	localparam logic [5:0] SwOp = 6'd43;
	localparam logic [5:0] HaltOp = 6'd63;
	localparam logic [5:0] UnknownOp = 6'd50;
	localparam logic [5:0] SllFn = 6'd0;
	localparam logic [5:0] AddFn = 6'd32;
	localparam logic [5:0] SubFn = 6'd34;
	localparam logic [5:0] AndFn = 6'd36;
	localparam logic [5:0] OrFn = 6'd37;
	localparam logic [5:0] SltFn = 6'd42;

	typedef struct packed {
		logic isRType;
		logic [5:0] code;
		logic [15:0] operandA;
		logic [15:0] operandB;
		logic [4:0] dest;
		logic usePause;
		logic unknownWord;
		logic [31:0] expected;
	} TestRow;

	logic clk;
	logic rst;
	logic start;
	logic pause;
	logic hostEnable;
	logic hostSelect;
	logic hostWrite;
	logic [31:0] hostAddress;
	logic [31:0] hostWriteData;
	logic [31:0] hostReadData;
	logic halted;

	TestRow testRows [RowCount];
	int rowFill;
	int errorCount;
	int cycleCount = 0;
	logic [31:0] lcgState;

	Processor #(
		.ProgramAddressWidth(ProgramAddressWidth),
		.DataAddressWidth(DataAddressWidth)
	) UUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pause(pause),
		.hostEnable(hostEnable),
		.hostSelect(hostSelect),
		.hostWrite(hostWrite),
		.hostAddress(hostAddress),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Hard stop for a run that never halts
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout after %0d cycles, halted never came", cycleCount);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Reference model: r1 holds sign-extended A, r2 holds zero-extended B
	function automatic logic [31:0] modelResult(input logic isRType, input logic [5:0] code,
			input logic [15:0] operandA, input logic [15:0] operandB, input logic [4:0] dest);
		logic [31:0] regA;
		logic [31:0] regB;
		logic [31:0] signB;
		logic [31:0] result;
		regA = {{16{operandA[15]}}, operandA};
		regB = {16'd0, operandB};
		signB = {{16{operandB[15]}}, operandB};
		result = 32'd0;
		if (isRType) begin
			case (code)
				// Shift amount comes from A's low bits
				SllFn: result = regB << operandA[4:0];
				AddFn: result = regA + regB;
				SubFn: result = regA - regB;
				AndFn: result = regA & regB;
				OrFn: result = regA | regB;
				SltFn: result = ($signed(regA) < $signed(regB)) ? 32'd1 : 32'd0;
				default: result = 32'd0;
			endcase
		end else begin
			case (code)
				AddiOp: result = regA + signB;
				AndiOp: result = regA & regB;
				OriOp: result = regA | regB;
				default: result = 32'd0;
			endcase
		end
		// r0 stays zero
		if (dest == 5'd0) begin
			result = 32'd0;
		end
		return result;
	endfunction

	function automatic logic [31:0] encodeRegister(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {6'd0, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] encodeImmediate(input logic [5:0] opcode, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] immediate);
		return {opcode, rs, rt, immediate};
	endfunction

	task automatic addRow(input logic isRType, input logic [5:0] code, input logic [15:0] operandA,
			input logic [15:0] operandB, input logic [4:0] dest, input logic usePause,
			input logic unknownWord);
		TestRow row;
		row.isRType = isRType;
		row.code = code;
		row.operandA = operandA;
		row.operandB = operandB;
		row.dest = dest;
		row.usePause = usePause;
		row.unknownWord = unknownWord;
		row.expected = modelResult(isRType, code, operandA, operandB, dest);
		testRows[rowFill] = row;
		rowFill++;
	endtask

	task automatic writeHostWord(input logic select, input logic [31:0] address,
			input logic [31:0] data);
		@(negedge clk);
		hostEnable = 1'b1;
		hostSelect = select;
		hostWrite = 1'b1;
		hostAddress = address;
		hostWriteData = data;
	endtask

	// Address on one falling edge, data is settled by the next
	task automatic readDataWord(input logic [31:0] address, output logic [31:0] value);
		@(negedge clk);
		hostEnable = 1'b1;
		hostSelect = 1'b1;
		hostWrite = 1'b0;
		hostAddress = address;
		@(negedge clk);
		hostEnable = 1'b0;
		value = hostReadData;
	endtask

	task automatic checkWord(input logic [31:0] address, input logic [31:0] expected);
		logic [31:0] value;
		readDataWord(address, value);
		assert (value === expected) else begin
			errorCount++;
			$display("Fail at %0t: data word %0d read %h, expected %h", $time, address, value,
				expected);
		end
	endtask

	task automatic runRow(input int index);
		TestRow row;
		logic [31:0] words [ProgramLength];
		int length;
		row = testRows[index];
		// addi r1, ori r2, operation, optional unknown word, sw, halt
		words[0] = encodeImmediate(AddiOp, 5'd0, 5'd1, row.operandA);
		words[1] = encodeImmediate(OriOp, 5'd0, 5'd2, row.operandB);
		if (row.isRType) begin
			words[2] = encodeRegister(row.code, 5'd1, 5'd2, row.dest, row.operandA[4:0]);
		end else begin
			words[2] = encodeImmediate(row.code, 5'd1, row.dest, row.operandB);
		end
		length = 3;
		if (row.unknownWord) begin
			words[3] = encodeImmediate(UnknownOp, 5'd1, row.dest, 16'hFFFF);
			length = 4;
		end
		words[length] = encodeImmediate(SwOp, 5'd0, row.dest, 16'(index));
		words[length + 1] = {HaltOp, 26'd0};
		length = length + 2;
		for (int i = 0; i < length; i++) begin
			writeHostWord(1'b0, i, words[i]);
		end
		@(negedge clk);
		hostEnable = 1'b0;
		hostWrite = 1'b0;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// Pause lands after the first two instructions
		if (row.usePause) begin
			repeat (3) @(negedge clk);
			pause = 1'b1;
			repeat (PauseCycles) @(negedge clk);
			assert (halted === 1'b0) else begin
				errorCount++;
				$display("Fail at %0t: halted rose during pause in row %0d", $time, index);
			end
			pause = 1'b0;
		end
		while (halted !== 1'b1) begin
			@(negedge clk);
		end
		// Earlier results must survive each rerun
		for (int r = 0; r <= index; r++) begin
			checkWord(r, testRows[r].expected);
		end
	endtask

	initial begin
		logic [31:0] randomA;
		logic [31:0] randomB;
		rst = 1'b0;
		start = 1'b0;
		pause = 1'b0;
		hostEnable = 1'b0;
		hostSelect = 1'b0;
		hostWrite = 1'b0;
		hostAddress = 32'd0;
		hostWriteData = 32'd0;
		errorCount = 0;
		rowFill = 0;
		lcgState = 32'h26a8;

		// R-type rows, some with random operands
		addRow(1'b1, AddFn, 16'h0123, 16'h0456, 5'd3, 1'b0, 1'b0);
		randomA = nextRandom();
		randomB = nextRandom();
		addRow(1'b1, SubFn, randomA[31:16], randomB[31:16], 5'd3, 1'b0, 1'b0);
		randomA = nextRandom();
		randomB = nextRandom();
		addRow(1'b1, AndFn, randomA[31:16], randomB[31:16], 5'd3, 1'b0, 1'b0);
		randomA = nextRandom();
		randomB = nextRandom();
		addRow(1'b1, OrFn, randomA[31:16], randomB[31:16], 5'd3, 1'b0, 1'b0);
		addRow(1'b1, SltFn, 16'hFFF0, 16'h0005, 5'd3, 1'b0, 1'b0);
		addRow(1'b1, SltFn, 16'h7FFF, 16'h0003, 5'd3, 1'b0, 1'b0);
		addRow(1'b1, SllFn, 16'h0004, 16'h8421, 5'd3, 1'b0, 1'b0);
		// Immediate extension
		addRow(1'b0, AddiOp, 16'h0010, 16'hFF00, 5'd3, 1'b0, 1'b0);
		addRow(1'b0, AndiOp, 16'hFFFF, 16'h8F0F, 5'd3, 1'b0, 1'b0);
		addRow(1'b0, OriOp, 16'h0000, 16'h8001, 5'd3, 1'b0, 1'b0);
		// Write into r0 is dropped
		addRow(1'b0, AddiOp, 16'h1234, 16'h0077, 5'd0, 1'b0, 1'b0);
		randomA = nextRandom();
		randomB = nextRandom();
		addRow(1'b1, AddFn, randomA[31:16], randomB[31:16], 5'd3, 1'b1, 1'b0);
		randomA = nextRandom();
		randomB = nextRandom();
		addRow(1'b1, SubFn, randomA[31:16], randomB[31:16], 5'd3, 1'b0, 1'b1);

		repeat (8) @(negedge clk);
		rst = 1'b1;

		// Clean state out of reset
		assert (halted === 1'b0) else begin
			errorCount++;
			$display("Fail at %0t: halted is %b after reset", $time, halted);
		end
		for (int a = 0; a < DataWords; a++) begin
			checkWord(a, 32'd0);
		end

		for (int r = 0; r < rowFill; r++) begin
			runRow(r);
		end

		$display("Rows run: %0d, errors: %0d", rowFill, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== Processor.f ====
source/ProcessorPackage.sv
source/HostPortIf.sv
source/RegisterFile.sv
source/RunController.sv
source/ProgramCounter.sv
source/InstructionMemory.sv
source/ExecuteUnit.sv
source/DataMemory.sv
source/Processor.sv
tb/ProcessorTb.sv

// ==== Bender.yml ====
package:
  name: processor

sources:
  - source/ProcessorPackage.sv
  - source/HostPortIf.sv
  - source/RegisterFile.sv
  - source/RunController.sv
  - source/ProgramCounter.sv
  - source/InstructionMemory.sv
  - source/ExecuteUnit.sv
  - source/DataMemory.sv
  - source/Processor.sv
  - target: test
    files:
      - tb/ProcessorTb.sv
